/* dv/dd_props.sv */
`default_nettype none

`include "dd_cfg.svh"

module dd_props (
	input wire logic clk_i,
	input wire logic rst_rd_flag1,
	input wire logic [`DD_NUM_CHAN-1:0] fifo_rd_req_o,
	input wire logic fdma_wvalid_i,
	input wire logic fdma_wbusy_i,
	input wire logic fdma_wareq_o
);
	timeunit 1ns;
	timeprecision 1ps;

	// Only one FIFO is read at a time
	rd_req_onehot: assert property (@(posedge clk_i) disable iff (!rst_rd_flag1)
		$onehot0(fifo_rd_req_o))
		else $error("more than one FIFO read request is set");

	// Reads only follow the engine's valid strobe
	rd_req_valid: assert property (@(posedge clk_i) disable iff (!rst_rd_flag1)
		(|fifo_rd_req_o) |-> fdma_wvalid_i)
		else $error("FIFO read request set without fdma_wvalid_i");

	// Request drops once the engine reports busy
	wareq_drop: assert property (@(posedge clk_i) disable iff (!rst_rd_flag1)
		fdma_wbusy_i |=> !fdma_wareq_o)
		else $error("fdma_wareq_o still high after busy was seen");

endmodule

bind dd_top dd_props u_props (
	.clk_i(clk_i),
	.rst_rd_flag1(rst_rd_flag1),
	.fifo_rd_req_o(fifo_rd_req_o),
	.fdma_wvalid_i(fdma_wvalid_i),
	.fdma_wbusy_i(fdma_wbusy_i),
	.fdma_wareq_o(fdma_wareq_o)
);

`default_nettype wire

/* dv/dd_tb.sv */
`default_nettype none

`include "dd_cfg.svh"

module dd_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import dd_pkg::*;

	localparam int NCH = `DD_NUM_CHAN;
	localparam int REQ_TIMEOUT = 50;

	logic clk_i;
	logic rst_rd_flag1;
	logic [NCH-1:0] rxd_ena;
	fifo_usedw_t fifo_usedw [NCH];
	word_t fifo_rd_data [NCH];
	logic [NCH-1:0] fifo_rd_req;
	ddr_count_t clr_usedw [NCH];
	ddr_count_t ddr_usedw [NCH];
	fdma_addr_t fdma_waddr;
	logic [15:0] fdma_wsize;
	logic fdma_wareq;
	logic fdma_wbusy;
	word_t fdma_wdata;
	logic fdma_wvalid;

	// Scoreboard of each channel's ring pointer and DDR fill
	ddr_count_t exp_ptr [NCH];
	ddr_count_t exp_used [NCH];
	fdma_addr_t last_addr;
	logic [31:0] lfsr;
	int checks;
	int errors;
	int start_errors;

	dd_top u_dut (
		.clk_i(clk_i),
		.rst_rd_flag1(rst_rd_flag1),
		.rxd_ena_i(rxd_ena),
		.fifo_usedw_i(fifo_usedw),
		.fifo_rd_data_i(fifo_rd_data),
		.fifo_rd_req_o(fifo_rd_req),
		.clr_usedw_i(clr_usedw),
		.ddr_usedw_o(ddr_usedw),
		.fdma_waddr_o(fdma_waddr),
		.fdma_wsize_o(fdma_wsize),
		.fdma_wareq_o(fdma_wareq),
		.fdma_wbusy_i(fdma_wbusy),
		.fdma_wdata_o(fdma_wdata),
		.fdma_wvalid_i(fdma_wvalid)
	);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic fdma_addr_t region_addr(input int ch);
		return `DD_MEM_OFFSET + fdma_addr_t'(ch) * `DD_REGION_STRIDE
			+ fdma_addr_t'(exp_ptr[ch]);
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		assert (exp == act) else begin
			$display("MISMATCH %s: expected %0h, actual %0h", name, exp, act);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		$display("%s: done, %0d errors", name, errors - start_errors);
		start_errors = errors;
	endtask

	// Pointer wraps to zero when the next burst would reach the limit
	task automatic model_commit(input int ch, input xfer_bytes_t bytes);
		ddr_count_t sum;
		sum = exp_ptr[ch] + ddr_count_t'(bytes);
		exp_ptr[ch] = (sum >= `DD_RING_LIMIT) ? '0 : sum;
		exp_used[ch] = exp_used[ch] + ddr_count_t'(bytes);
	endtask

	// FDMA engine model, one write transfer for the expected channel
	task automatic serve_write(input string name, input int ch, input xfer_bytes_t bytes);
		int wait_cnt;
		int busy_len;
		wait_cnt = 0;
		while (!fdma_wareq && wait_cnt < REQ_TIMEOUT) begin
			@(negedge clk_i);
			wait_cnt++;
		end
		if (!fdma_wareq) begin
			$display("ERROR: %s saw no write request within %0d cycles", name, REQ_TIMEOUT);
			$display("Test failed");
			$finish;
		end else begin
			last_addr = fdma_waddr;
			check_value(name, region_addr(ch), fdma_waddr);
			check_value(name, 32'(bytes >> 2), 32'(fdma_wsize));
			busy_len = int'(rand_bits(3)) + 1;
			fdma_wbusy = 1'b1;
			fdma_wvalid = 1'b1;
			repeat (busy_len) begin
				@(negedge clk_i);
				check_value(name, 32'(1 << ch), 32'(fifo_rd_req));
				check_value(name, fifo_rd_data[ch], fdma_wdata);
			end
			fdma_wbusy = 1'b0;
			fdma_wvalid = 1'b0;
			// Commit lands on the edge after busy falls
			@(negedge clk_i);
			model_commit(ch, bytes);
			check_value(name, 32'(exp_used[ch]), 32'(ddr_usedw[ch]));
		end
	endtask

	task automatic test_reset();
		check_value("reset", 32'h0, 32'(fdma_wareq));
		check_value("reset", 32'h0, 32'(fifo_rd_req));
		check_value("reset", `DD_MEM_OFFSET, fdma_waddr);
		for (int i = 0; i < NCH; i++) begin
			check_value("reset", 32'h0, 32'(ddr_usedw[i]));
		end
		end_test("reset");
	endtask

	task automatic test_full_burst();
		fifo_usedw[2] = `DD_BURST_WORDS;
		serve_write("full_burst", 2, `DD_BURST_BYTES);
		fifo_usedw[2] = '0;
		end_test("full_burst");
	endtask

	task automatic test_flush_hold();
		fifo_usedw_t fill;
		fill = fifo_usedw_t'(rand_bits(10));
		if (fill == '0) begin
			fill = 13'd1;
		end
		fifo_usedw[0] = fill;
		// Partial fill waits while receive is still on
		repeat (20) begin
			@(negedge clk_i);
			check_value("flush_hold", 32'h0, 32'(fdma_wareq));
		end
		rxd_ena[0] = 1'b0;
		serve_write("flush_hold", 0, xfer_bytes_t'(fill) * 16'd4);
		fifo_usedw[0] = '0;
		rxd_ena[0] = 1'b1;
		end_test("flush_hold");
	endtask

	task automatic test_priority();
		fifo_usedw[0] = `DD_BURST_WORDS;
		fifo_usedw[3] = `DD_BURST_WORDS;
		serve_write("priority", 0, `DD_BURST_BYTES);
		fifo_usedw[0] = '0;
		serve_write("priority", 3, `DD_BURST_BYTES);
		fifo_usedw[3] = '0;
		end_test("priority");
	endtask

	task automatic test_ring_wrap();
		logic wrapped;
		wrapped = 1'b0;
		fifo_usedw[1] = `DD_BURST_WORDS;
		while (!wrapped) begin
			if (exp_ptr[1] + ddr_count_t'(`DD_BURST_BYTES) >= `DD_RING_LIMIT) begin
				wrapped = 1'b1;
			end
			serve_write("ring_wrap", 1, `DD_BURST_BYTES);
		end
		// First burst after the wrap starts at the region base
		serve_write("ring_wrap", 1, `DD_BURST_BYTES);
		fifo_usedw[1] = '0;
		check_value("ring_wrap", `DD_MEM_OFFSET + `DD_REGION_STRIDE, last_addr);
		end_test("ring_wrap");
	endtask

	task automatic test_drain();
		ddr_count_t drain;
		drain = ddr_count_t'(rand_bits(12));
		if (drain == '0) begin
			drain = 25'd1;
		end
		clr_usedw[2] = drain;
		@(negedge clk_i);
		clr_usedw[2] = '0;
		exp_used[2] = exp_used[2] - drain;
		check_value("drain", 32'(exp_used[2]), 32'(ddr_usedw[2]));
		@(negedge clk_i);
		check_value("drain", 32'(exp_used[2]), 32'(ddr_usedw[2]));
		end_test("drain");
	endtask

	initial begin
		lfsr = 32'h8ae9_982f;
		checks = 0;
		errors = 0;
		start_errors = 0;
		rst_rd_flag1 = 1'b0;
		rxd_ena = '1;
		fdma_wbusy = 1'b0;
		fdma_wvalid = 1'b0;
		for (int i = 0; i < NCH; i++) begin
			fifo_usedw[i] = '0;
			clr_usedw[i] = '0;
			fifo_rd_data[i] = rand_bits(32);
			exp_ptr[i] = '0;
			exp_used[i] = '0;
		end
		repeat (16) @(negedge clk_i);
		rst_rd_flag1 = 1'b1;
		@(negedge clk_i);
		test_reset();
		test_full_burst();
		test_flush_hold();
		test_priority();
		test_ring_wrap();
		test_drain();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+verilog
verilog/dd_pkg.sv
verilog/dd_chan_if.sv
verilog/dd_chan.sv
verilog/dd_sched.sv
verilog/dd_data_mux.sv
verilog/dd_top.sv
dv/dd_props.sv
dv/dd_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module dd_tb -f project.f -o dd_tb_sim

# Pass or fail is decided by the search below
out=$(./obj_dir/dd_tb_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Test passed'; then
	exit 0
else
	exit 1
fi

/* verilog/dd_cfg.svh */
`ifndef DD_CFG_SVH
`define DD_CFG_SVH

// Number of write channels
`define DD_NUM_CHAN 4

// FIFO fill in words that triggers a full burst
`define DD_BURST_WORDS 13'd1024

// Full burst length in bytes
`define DD_BURST_BYTES 16'd4096

// Byte offset at which a channel ring pointer wraps
`define DD_RING_LIMIT 25'h1f0_0000

// DDR base address and distance between channel regions
`define DD_MEM_OFFSET 32'h3000_0000
`define DD_REGION_STRIDE 32'h0200_0000

`endif

/* verilog/dd_chan.sv */
`default_nettype none

`include "dd_cfg.svh"

module dd_chan #(
	parameter dd_pkg::chan_idx_t CHAN = '0
) (
	input wire logic clk_i,
	input wire logic rst_rd_flag1,
	input wire logic rxd_ena_i,
	input dd_pkg::fifo_usedw_t fifo_usedw_i,
	input dd_pkg::ddr_count_t clr_usedw_i,
	output dd_pkg::ddr_count_t ddr_usedw_o,
	dd_chan_if.chan_mp chan_io
);
	import dd_pkg::*;

	ddr_count_t ptr_q;
	ddr_count_t usedw_q;
	ddr_count_t ptr_sum;
	ddr_count_t add_bytes;
	xfer_bytes_t burst_bytes;
	logic full_burst;

	// Full burst, or flush whatever is left once receive stops
	assign full_burst = (fifo_usedw_i >= `DD_BURST_WORDS);
	assign chan_io.ready = full_burst || ((fifo_usedw_i != '0) && !rxd_ena_i);

	// Partial fill is sent as whole 32-bit words
	assign burst_bytes = full_burst ? `DD_BURST_BYTES :
		xfer_bytes_t'({fifo_usedw_i, 2'b00});
	assign chan_io.xfer_bytes = burst_bytes;

	// Region base of this channel plus ring pointer
	assign chan_io.xfer_addr = fdma_addr_t'(`DD_MEM_OFFSET)
		+ fdma_addr_t'(CHAN) * `DD_REGION_STRIDE
		+ fdma_addr_t'(ptr_q);

	assign ptr_sum = ptr_q + ddr_count_t'(burst_bytes);
	assign add_bytes = chan_io.commit ? ddr_count_t'(burst_bytes) : '0;

	// Ring pointer
	always_ff @(posedge clk_i or negedge rst_rd_flag1) begin
		if (!rst_rd_flag1) begin
			ptr_q <= '0;
		end else if (chan_io.commit) begin
			if (ptr_sum >= `DD_RING_LIMIT) begin
				ptr_q <= '0;
			end else begin
				ptr_q <= ptr_sum;
			end
		end
	end

	// DDR fill, drained from outside every cycle
	always_ff @(posedge clk_i or negedge rst_rd_flag1) begin
		if (!rst_rd_flag1) begin
			usedw_q <= '0;
		end else begin
			usedw_q <= usedw_q - clr_usedw_i + add_bytes;
		end
	end

	assign ddr_usedw_o = usedw_q;

endmodule

`default_nettype wire

/* verilog/dd_chan_if.sv */
`default_nettype none

interface dd_chan_if;
	import dd_pkg::*;

	// Channel has data for a burst
	logic ready;
	// Burst length and start address offered by the channel
	xfer_bytes_t xfer_bytes;
	fdma_addr_t xfer_addr;
	// One-cycle pulse when the granted burst has completed
	logic commit;

	modport chan_mp (
		output ready,
		output xfer_bytes,
		output xfer_addr,
		input commit
	);

	modport sched_mp (
		input ready,
		input xfer_bytes,
		input xfer_addr,
		output commit
	);

endinterface

`default_nettype wire

/* verilog/dd_data_mux.sv */
`default_nettype none

`include "dd_cfg.svh"

module dd_data_mux (
	input dd_pkg::chan_idx_t grant_sel_i,
	input dd_pkg::word_t fifo_rd_data_i [`DD_NUM_CHAN],
	input wire logic fdma_wvalid_i,
	output dd_pkg::word_t fdma_wdata_o,
	output logic [`DD_NUM_CHAN-1:0] fifo_rd_req_o
);

	// Granted FIFO feeds the engine
	assign fdma_wdata_o = fifo_rd_data_i[grant_sel_i];

	// Engine pulls words from the granted FIFO only
	always_comb begin
		fifo_rd_req_o = '0;
		fifo_rd_req_o[grant_sel_i] = fdma_wvalid_i;
	end

endmodule

`default_nettype wire

/* verilog/dd_pkg.sv */
`default_nettype none

package dd_pkg;

	// Channel number
	typedef logic [1:0] chan_idx_t;

	// Front-end FIFO fill in words
	typedef logic [12:0] fifo_usedw_t;

	// Byte counts inside one DDR region
	typedef logic [24:0] ddr_count_t;

	typedef logic [15:0] xfer_bytes_t;
	typedef logic [31:0] fdma_addr_t;
	typedef logic [31:0] word_t;

	// Scheduler states
	typedef enum logic [1:0] {
		IDLE,
		WAIT_ACK,
		WAIT_OVER
	} sched_state_e;

endpackage

`default_nettype wire

/* verilog/dd_sched.sv */
`default_nettype none

`include "dd_cfg.svh"

module dd_sched (
	input wire logic clk_i,
	input wire logic rst_rd_flag1,
	input wire logic fdma_wbusy_i,
	output logic fdma_wareq_o,
	output dd_pkg::fdma_addr_t fdma_waddr_o,
	output logic [15:0] fdma_wsize_o,
	output dd_pkg::chan_idx_t grant_sel_o,
	dd_chan_if.sched_mp chan_io [`DD_NUM_CHAN]
);
	import dd_pkg::*;

	sched_state_e state_q;
	chan_idx_t grant_sel_q;
	chan_idx_t grant_idx;
	logic grant_any;
	xfer_bytes_t size_q;
	fdma_addr_t addr_q;
	logic busy_q;
	logic busy_rise;
	logic busy_fall;
	logic [`DD_NUM_CHAN-1:0] ready_vec;
	logic [`DD_NUM_CHAN-1:0] commit_vec;
	xfer_bytes_t bytes_vec [`DD_NUM_CHAN];
	fdma_addr_t addr_vec [`DD_NUM_CHAN];

	// Flatten the channel interfaces
	for (genvar g = 0; g < `DD_NUM_CHAN; g++) begin : g_chan
		assign ready_vec[g] = chan_io[g].ready;
		assign bytes_vec[g] = chan_io[g].xfer_bytes;
		assign addr_vec[g] = chan_io[g].xfer_addr;
		assign chan_io[g].commit = commit_vec[g];
	end

	// Lowest ready channel wins
	always_comb begin
		grant_any = 1'b0;
		grant_idx = '0;
		for (int i = `DD_NUM_CHAN - 1; i >= 0; i--) begin
			if (ready_vec[i]) begin
				grant_any = 1'b1;
				grant_idx = chan_idx_t'(i);
			end
		end
	end

	// Busy edges from the engine
	always_ff @(posedge clk_i or negedge rst_rd_flag1) begin
		if (!rst_rd_flag1) begin
			busy_q <= 1'b0;
		end else begin
			busy_q <= fdma_wbusy_i;
		end
	end

	assign busy_rise = !busy_q && fdma_wbusy_i;
	assign busy_fall = busy_q && !fdma_wbusy_i;

	always_ff @(posedge clk_i or negedge rst_rd_flag1) begin
		if (!rst_rd_flag1) begin
			state_q <= IDLE;
		end else begin
			case (state_q)
				IDLE: if (grant_any && !fdma_wbusy_i) state_q <= WAIT_ACK;
				WAIT_ACK: if (busy_rise) state_q <= WAIT_OVER;
				WAIT_OVER: if (busy_fall) state_q <= IDLE;
				default: state_q <= IDLE;
			endcase
		end
	end

	// Selection, size and address held for the whole transfer
	always_ff @(posedge clk_i or negedge rst_rd_flag1) begin
		if (!rst_rd_flag1) begin
			grant_sel_q <= '0;
			size_q <= '0;
			addr_q <= `DD_MEM_OFFSET;
		end else if ((state_q == IDLE) && grant_any && !fdma_wbusy_i) begin
			grant_sel_q <= grant_idx;
			size_q <= bytes_vec[grant_idx];
			addr_q <= addr_vec[grant_idx];
		end
	end

	// Request drops once the engine shows busy
	always_ff @(posedge clk_i or negedge rst_rd_flag1) begin
		if (!rst_rd_flag1) begin
			fdma_wareq_o <= 1'b0;
		end else begin
			fdma_wareq_o <= (state_q == WAIT_ACK) && !fdma_wbusy_i;
		end
	end

	always_comb begin
		commit_vec = '0;
		commit_vec[grant_sel_q] = (state_q == WAIT_OVER) && busy_fall;
	end

	// Engine counts 32-bit words
	assign fdma_wsize_o = size_q >> 2;
	assign fdma_waddr_o = addr_q;
	assign grant_sel_o = grant_sel_q;

endmodule

`default_nettype wire

/* verilog/dd_top.sv */
`default_nettype none

`include "dd_cfg.svh"

module dd_top (
	input wire logic clk_i,
	input wire logic rst_rd_flag1,
	input wire logic [`DD_NUM_CHAN-1:0] rxd_ena_i,

	// Front-end FIFOs
	input dd_pkg::fifo_usedw_t fifo_usedw_i [`DD_NUM_CHAN],
	input dd_pkg::word_t fifo_rd_data_i [`DD_NUM_CHAN],
	output logic [`DD_NUM_CHAN-1:0] fifo_rd_req_o,

	// DDR fill per channel and external drain
	input dd_pkg::ddr_count_t clr_usedw_i [`DD_NUM_CHAN],
	output dd_pkg::ddr_count_t ddr_usedw_o [`DD_NUM_CHAN],

	// FDMA write engine
	output dd_pkg::fdma_addr_t fdma_waddr_o,
	output logic [15:0] fdma_wsize_o,
	output logic fdma_wareq_o,
	input wire logic fdma_wbusy_i,
	output dd_pkg::word_t fdma_wdata_o,
	input wire logic fdma_wvalid_i
);
	import dd_pkg::*;

	chan_idx_t grant_sel;

	dd_chan_if chan_if [`DD_NUM_CHAN] ();

	for (genvar g = 0; g < `DD_NUM_CHAN; g++) begin : g_chan
		dd_chan #(
			.CHAN(chan_idx_t'(g))
		) u_chan (
			.clk_i(clk_i),
			.rst_rd_flag1(rst_rd_flag1),
			.rxd_ena_i(rxd_ena_i[g]),
			.fifo_usedw_i(fifo_usedw_i[g]),
			.clr_usedw_i(clr_usedw_i[g]),
			.ddr_usedw_o(ddr_usedw_o[g]),
			.chan_io(chan_if[g])
		);
	end

	dd_sched u_sched (
		.clk_i(clk_i),
		.rst_rd_flag1(rst_rd_flag1),
		.fdma_wbusy_i(fdma_wbusy_i),
		.fdma_wareq_o(fdma_wareq_o),
		.fdma_waddr_o(fdma_waddr_o),
		.fdma_wsize_o(fdma_wsize_o),
		.grant_sel_o(grant_sel),
		.chan_io(chan_if)
	);

	// Write data path to the engine
	dd_data_mux u_data_mux (
		.grant_sel_i(grant_sel),
		.fifo_rd_data_i(fifo_rd_data_i),
		.fdma_wvalid_i(fdma_wvalid_i),
		.fdma_wdata_o(fdma_wdata_o),
		.fifo_rd_req_o(fifo_rd_req_o)
	);

endmodule

`default_nettype wire
